/* list.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_bus_pkg.sv
verilog/rv_bus_arbiter.sv
verilog/rv_prefetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_core.sv
sim/tb_memory.sv
sim/tb_rv_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_rv_core -o tb_rv_core
	./obj_dir/tb_rv_core > sim.log 2>&1 || true
	@if grep -q "Test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test completed successfully" sim.log || (echo "simulation FAILED"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* sim/tb_rv_core.sv */
`include "rv_core_macros.svh"

module tb_rv_core;

  localparam int ROWS = 70;
  localparam int CYCLES_PER_ROW = 40;

  typedef struct packed {
    logic [31:0] instr;
    logic        logs_store;
    logic [31:0] st_adr;
    logic [31:0] st_dat;
    logic        ext;
  } row_t;

  logic                    clk_i;
  logic                    reset_i;
  logic                    ext_req = 1'b0;
  logic [`RV_ADR_BITS-1:0] bus_adr;
  logic [`RV_XLEN-1:0]     bus_dat_w, bus_dat_r, debug_pc;
  logic [3:0]              bus_sel;
  logic                    bus_cyc, bus_stb, bus_we, bus_ack, ext_grant;

  row_t        rows [ROWS];
  int          row_cnt;
  int          n_exp;
  int          ext_cnt;
  int          grant_rises;
  int          k;
  logic [31:0] last_ext_pc = 32'hffff_ffff;
  logic [31:0] pc_at_last_store;
  logic        grant_prev;
  logic        open_prev;

  rv_core DUT (
    .clk_i(clk_i), .reset_i(reset_i), .bus_dat_i(bus_dat_r), .bus_ack_i(bus_ack),
    .ext_req_i(ext_req), .bus_adr_o(bus_adr), .bus_dat_o(bus_dat_w), .bus_sel_o(bus_sel),
    .bus_cyc_o(bus_cyc), .bus_stb_o(bus_stb), .bus_we_o(bus_we),
    .ext_grant_o(ext_grant), .debug_pc_o(debug_pc)
  );

  tb_memory u_mem (
    .clk_i(clk_i), .reset_i(reset_i), .cyc_i(bus_cyc), .stb_i(bus_stb), .we_i(bus_we),
    .sel_i(bus_sel), .adr_i(bus_adr), .dat_i(bus_dat_w), .ack_o(bus_ack), .dat_o(bus_dat_r)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h expected 0x%08h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // rv32i instruction formats
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] up);
    return {up, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_row(input logic [31:0] instr, input logic logs,
                         input logic [31:0] adr, input logic [31:0] dat, input logic ext);
    rows[row_cnt] = '{instr: instr, logs_store: logs, st_adr: adr, st_dat: dat, ext: ext};
    row_cnt++;
    if (logs) n_exp++;
  endtask

  task automatic add_plain(input logic [31:0] instr);
    add_row(instr, 1'b0, 32'h0, 32'h0, 1'b0);
  endtask

  // taken branch skips the marker, the not-taken one lets it store
  task automatic add_branch_pair(input logic [2:0] f3, input logic [4:0] t1,
                                 input logic [4:0] t2, input logic [4:0] n1,
                                 input logic [4:0] n2, input logic [11:0] mark);
    add_plain(enc_b(f3, t1, t2, 13'd8));
    add_plain(enc_sw(5'd3, mark));
    add_plain(enc_b(f3, n1, n2, 13'd8));
    add_row(enc_sw(5'd3, mark + 12'd4), 1'b1, {20'h0, mark + 12'd4}, 32'h7, 1'b0);
  endtask

  task automatic build_table();
    row_cnt = 0;
    n_exp   = 0;
    add_plain(enc_lui(5'd1, 20'h80000));
    add_plain(enc_i(12'hffb, 5'd0, 3'b000, 5'd2, 7'b0010011));
    add_plain(enc_i(12'h007, 5'd0, 3'b000, 5'd3, 7'b0010011));
    add_row(enc_sw(5'd1, 12'h200), 1'b1, 32'h200, 32'h8000_0000, 1'b0);
    add_row(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd4), 1'b0, 32'h0, 32'h0, 1'b1);
    add_row(enc_sw(5'd4, 12'h204), 1'b1, 32'h204, 32'h0000_0002, 1'b0);
    add_plain(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd5));
    add_row(enc_sw(5'd5, 12'h208), 1'b1, 32'h208, 32'h0000_000c, 1'b0);
    add_plain(enc_r(7'h20, 5'd3, 5'd1, 3'b101, 5'd6));
    add_row(enc_sw(5'd6, 12'h20c), 1'b1, 32'h20c, 32'hff00_0000, 1'b0);
    add_plain(enc_r(7'h00, 5'd3, 5'd1, 3'b101, 5'd7));
    add_row(enc_sw(5'd7, 12'h210), 1'b1, 32'h210, 32'h0100_0000, 1'b0);
    add_plain(enc_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd8));
    add_plain(enc_r(7'h00, 5'd3, 5'd2, 3'b011, 5'd9));
    add_row(enc_sw(5'd8, 12'h214), 1'b1, 32'h214, 32'h0000_0001, 1'b0);
    add_row(enc_sw(5'd9, 12'h218), 1'b1, 32'h218, 32'h0000_0000, 1'b0);
    add_plain(enc_i(12'h0f0, 5'd2, 3'b100, 5'd10, 7'b0010011));
    add_plain(enc_i(12'h100, 5'd3, 3'b110, 5'd11, 7'b0010011));
    add_plain(enc_i(12'h07f, 5'd2, 3'b111, 5'd12, 7'b0010011));
    add_plain(enc_i(12'h004, 5'd3, 3'b001, 5'd13, 7'b0010011));
    add_plain(enc_i(12'h401, 5'd2, 3'b101, 5'd14, 7'b0010011));
    add_plain(enc_i(12'hffc, 5'd2, 3'b010, 5'd15, 7'b0010011));
    add_plain(enc_i(12'hfff, 5'd3, 3'b011, 5'd16, 7'b0010011));
    add_row(enc_sw(5'd10, 12'h21c), 1'b1, 32'h21c, 32'hffff_ff0b, 1'b0);
    add_row(enc_sw(5'd11, 12'h220), 1'b1, 32'h220, 32'h0000_0107, 1'b0);
    add_row(enc_sw(5'd12, 12'h224), 1'b1, 32'h224, 32'h0000_007b, 1'b0);
    add_row(enc_sw(5'd13, 12'h228), 1'b1, 32'h228, 32'h0000_0070, 1'b0);
    add_row(enc_sw(5'd14, 12'h22c), 1'b1, 32'h22c, 32'hffff_fffd, 1'b0);
    add_row(enc_sw(5'd15, 12'h230), 1'b1, 32'h230, 32'h0000_0001, 1'b0);
    add_row(enc_sw(5'd16, 12'h234), 1'b1, 32'h234, 32'h0000_0001, 1'b0);
    add_plain(enc_r(7'h00, 5'd3, 5'd3, 3'b001, 5'd17));
    add_plain(enc_r(7'h00, 5'd3, 5'd2, 3'b110, 5'd18));
    add_plain(enc_r(7'h00, 5'd3, 5'd2, 3'b111, 5'd19));
    add_plain(enc_r(7'h00, 5'd3, 5'd2, 3'b100, 5'd20));
    add_row(enc_sw(5'd17, 12'h238), 1'b1, 32'h238, 32'h0000_0380, 1'b0);
    add_row(enc_sw(5'd18, 12'h23c), 1'b1, 32'h23c, 32'hffff_ffff, 1'b0);
    add_row(enc_sw(5'd19, 12'h240), 1'b1, 32'h240, 32'h0000_0003, 1'b0);
    add_row(enc_sw(5'd20, 12'h244), 1'b1, 32'h244, 32'hffff_fffc, 1'b0);
    // word round trip through memory
    add_plain(enc_i(12'h200, 5'd0, 3'b010, 5'd21, 7'b0000011));
    add_row(enc_sw(5'd21, 12'h248), 1'b1, 32'h248, 32'h8000_0000, 1'b1);
    add_plain(enc_i(12'h005, 5'd0, 3'b000, 5'd0, 7'b0010011));
    add_row(enc_sw(5'd0, 12'h24c), 1'b1, 32'h24c, 32'h0000_0000, 1'b0);
    // x2 = -5, x3 = 7
    add_branch_pair(3'b000, 5'd3, 5'd3, 5'd2, 5'd3, 12'h300);
    add_branch_pair(3'b001, 5'd2, 5'd3, 5'd3, 5'd3, 12'h308);
    add_branch_pair(3'b100, 5'd2, 5'd3, 5'd3, 5'd2, 12'h310);
    add_branch_pair(3'b101, 5'd3, 5'd2, 5'd2, 5'd3, 12'h318);
    add_branch_pair(3'b110, 5'd3, 5'd2, 5'd2, 5'd3, 12'h320);
    add_branch_pair(3'b111, 5'd2, 5'd3, 5'd3, 5'd2, 12'h328);
    // jal at row 66 links 0x10c
    add_plain(enc_jal(5'd22, 21'd8));
    add_plain(enc_sw(5'd3, 12'h330));
    add_row(enc_sw(5'd22, 12'h334), 1'b1, 32'h334, 32'h0000_010c, 1'b1);
    add_plain(enc_jal(5'd0, 21'd0));
  endtask

  function automatic logic pc_is_ext_row(input logic [31:0] pc);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < row_cnt; i++) begin
      if (rows[i].ext && pc == 32'(i * 4)) hit = 1'b1;
    end
    return hit;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    reset_i = 1'b1;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
  end

  // external master asks for the bus for a few cycles on flagged rows
  always @(posedge clk_i) begin
    if (reset_i) begin
      ext_req <= 1'b0;
      ext_cnt <= 0;
    end else if (ext_cnt != 0) begin
      ext_cnt <= ext_cnt - 1;
      if (ext_cnt == 1) ext_req <= 1'b0;
    end else if (pc_is_ext_row(debug_pc) && debug_pc != last_ext_pc) begin
      ext_req     <= 1'b1;
      ext_cnt     <= 8;
      last_ext_pc <= debug_pc;
    end
  end

  always @(negedge clk_i) begin
    if (reset_i) begin
      grant_prev  = 1'b0;
      open_prev   = 1'b0;
      grant_rises = 0;
    end else begin
      if (ext_grant) check_value("bus_cyc_o", {31'b0, bus_cyc}, 32'h0);
      if (ext_grant && !grant_prev) begin
        grant_rises++;
        check_value("open_txn_at_ext_grant", {31'b0, open_prev}, 32'h0);
      end
      grant_prev = ext_grant;
      open_prev  = bus_cyc && bus_stb && !bus_ack;
    end
  end

  initial begin
    repeat (ROWS * CYCLES_PER_ROW + 50) @(posedge clk_i);
    $display("timeout: the program did not finish its stores in time");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    build_table();
    u_mem.fill_pattern();
    for (int i = 0; i < row_cnt; i++) u_mem.load_word(i, rows[i].instr);
    @(negedge clk_i);
    while (reset_i || u_mem.log_cnt < n_exp) @(negedge clk_i);
    // last store retires, then the closing jal holds the pc
    pc_at_last_store = debug_pc;
    while (debug_pc == pc_at_last_store) @(negedge clk_i);
    check_value("debug_pc_o", debug_pc, 32'((row_cnt - 1) * 4));
    check_value("store_count", 32'(u_mem.log_cnt), 32'(n_exp));
    k = 0;
    for (int i = 0; i < row_cnt; i++) begin
      if (rows[i].logs_store) begin
        check_value("store_adr", u_mem.log_adr[k], rows[i].st_adr);
        check_value("store_dat", u_mem.log_dat[k], rows[i].st_dat);
        k++;
      end
    end
    check_value("ext_grant_o_seen", (grant_rises != 0) ? 32'd1 : 32'd0, 32'd1);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* sim/tb_memory.sv */
`include "rv_core_macros.svh"

module tb_memory (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    cyc_i,
  input  logic                    stb_i,
  input  logic                    we_i,
  input  logic [3:0]              sel_i,
  input  logic [`RV_ADR_BITS-1:0] adr_i,
  input  logic [`RV_XLEN-1:0]     dat_i,
  output logic                    ack_o,
  output logic [`RV_XLEN-1:0]     dat_o
);

  logic [`RV_XLEN-1:0] mem [256];
  logic [31:0]         log_adr [64];
  logic [31:0]         log_dat [64];
  int                  log_cnt;
  logic [31:0]         lfsr_q;
  logic                busy_q;
  logic [1:0]          wait_q;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic fill_pattern();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hc0de_0000 | 32'(i);
    end
  endtask

  task automatic load_word(input int idx, input logic [31:0] word);
    mem[idx[7:0]] = word;
  endtask

  always @(posedge clk_i) begin : slave
    logic [31:0] s1;
    logic [31:0] s2;
    if (reset_i) begin
      ack_o   <= 1'b0;
      busy_q  <= 1'b0;
      wait_q  <= 2'd0;
      lfsr_q  <= 32'hd33e;
      log_cnt <= 0;
    end else if (ack_o) begin
      ack_o <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (!busy_q) begin
        // two lfsr steps give a delay of 0 to 3 extra cycles
        s1 = lfsr_next(lfsr_q);
        s2 = lfsr_next(s1);
        lfsr_q <= s2;
        wait_q <= {lfsr_q[0], s1[0]};
        busy_q <= 1'b1;
      end else if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else begin
        ack_o  <= 1'b1;
        busy_q <= 1'b0;
        dat_o  <= mem[adr_i[7:0]];
        if (we_i && sel_i == 4'hf) begin
          mem[adr_i[7:0]] <= dat_i;
          if (log_cnt < 64) begin
            log_adr[log_cnt[5:0]] <= {adr_i, 2'b00};
            log_dat[log_cnt[5:0]] <= dat_i;
          end
          log_cnt <= log_cnt + 1;
        end
      end
    end
  end

endmodule

/* verilog/rv_core.sv */
`include "rv_core_macros.svh"

module rv_core (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [`RV_XLEN-1:0]     bus_dat_i,
  input  logic                    bus_ack_i,
  input  logic                    ext_req_i,
  output logic [`RV_ADR_BITS-1:0] bus_adr_o,
  output logic [`RV_XLEN-1:0]     bus_dat_o,
  output logic [3:0]              bus_sel_o,
  output logic                    bus_cyc_o,
  output logic                    bus_stb_o,
  output logic                    bus_we_o,
  output logic                    ext_grant_o,
  output logic [`RV_XLEN-1:0]     debug_pc_o
);

  typedef enum logic [4:0] {
    ST_FETCH     = 5'b00001,
    ST_DECODE    = 5'b00010,
    ST_EXECUTE   = 5'b00100,
    ST_MEMORY    = 5'b01000,
    ST_WRITEBACK = 5'b10000
  } stage_e;

  stage_e               stage_q;
  logic [`RV_XLEN-1:0]  pc_q;
  logic                 fetch_start_q, mem_start_q;
  rv_bus_pkg::bus_req_t fetch_req, mem_req, bus_req;
  rv_bus_pkg::bus_rsp_t fetch_rsp, mem_rsp, bus_rsp;
  logic [`RV_XLEN-1:0]  instr, rs1, rs2, result, target, rdata, rd_data;
  logic                 fetch_done, mem_done, taken, rd_write;
  rv_isa_pkg::decoded_t dec;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_q       <= ST_FETCH;
      pc_q          <= `RV_RESET_PC;
      fetch_start_q <= 1'b1;
      mem_start_q   <= 1'b0;
    end else begin
      fetch_start_q <= (stage_q == ST_WRITEBACK);
      mem_start_q   <= (stage_q == ST_EXECUTE) && (dec.load || dec.store);
      case (stage_q)
        ST_FETCH:   if (fetch_done) stage_q <= ST_DECODE;
        ST_DECODE:  stage_q <= ST_EXECUTE;
        ST_EXECUTE: stage_q <= (dec.load || dec.store) ? ST_MEMORY : ST_WRITEBACK;
        ST_MEMORY:  if (mem_done) stage_q <= ST_WRITEBACK;
        default: begin
          stage_q <= ST_FETCH;
          pc_q    <= taken ? target : pc_q + 32'd4;
        end
      endcase
    end
  end

  assign rd_data  = dec.load ? rdata : result;
  assign rd_write = (stage_q == ST_WRITEBACK) && dec.reg_write && (dec.rd != '0);

  rv_bus_arbiter u_arbiter (
    .clk_i(clk_i), .reset_i(reset_i),
    .fetch_req_i(fetch_req), .mem_req_i(mem_req), .ext_req_i(ext_req_i),
    .bus_rsp_i(bus_rsp), .bus_req_o(bus_req),
    .fetch_rsp_o(fetch_rsp), .mem_rsp_o(mem_rsp), .ext_grant_o(ext_grant_o)
  );

  rv_prefetch u_prefetch (
    .clk_i(clk_i), .reset_i(reset_i), .start_i(fetch_start_q), .pc_i(pc_q),
    .bus_rsp_i(fetch_rsp), .bus_req_o(fetch_req), .instr_o(instr), .done_o(fetch_done)
  );

  rv_decode u_decode (
    .clk_i(clk_i), .load_i(stage_q == ST_DECODE), .instr_i(instr), .dec_o(dec)
  );

  rv_regfile u_regfile (
    .clk_i(clk_i), .write_i(rd_write), .rd_addr_i(dec.rd),
    .rs1_addr_i(dec.rs1), .rs2_addr_i(dec.rs2), .rd_data_i(rd_data),
    .rs1_o(rs1), .rs2_o(rs2)
  );

  rv_execute u_execute (
    .clk_i(clk_i), .load_i(stage_q == ST_EXECUTE), .dec_i(dec), .pc_i(pc_q),
    .rs1_i(rs1), .rs2_i(rs2), .result_o(result), .target_o(target), .taken_o(taken)
  );

  // address comes from the registered add, store data straight from rs2
  rv_memory u_memory (
    .clk_i(clk_i), .reset_i(reset_i), .start_i(mem_start_q), .write_i(dec.store),
    .addr_i(result), .wdata_i(rs2), .bus_rsp_i(mem_rsp), .bus_req_o(mem_req),
    .rdata_o(rdata), .done_o(mem_done)
  );

  assign bus_rsp    = '{ack: bus_ack_i, dat: bus_dat_i};
  assign bus_adr_o  = bus_req.adr;
  assign bus_dat_o  = bus_req.dat;
  assign bus_sel_o  = bus_req.sel;
  assign bus_cyc_o  = bus_req.cyc;
  assign bus_stb_o  = bus_req.stb;
  assign bus_we_o   = bus_req.we;
  assign debug_pc_o = pc_q;

endmodule

/* verilog/rv_memory.sv */
`include "rv_core_macros.svh"

module rv_memory (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic                 write_i,
  input  logic [`RV_XLEN-1:0]  addr_i,
  input  logic [`RV_XLEN-1:0]  wdata_i,
  input  rv_bus_pkg::bus_rsp_t bus_rsp_i,
  output rv_bus_pkg::bus_req_t bus_req_o,
  output logic [`RV_XLEN-1:0]  rdata_o,
  output logic                 done_o
);

  logic                    cyc_q;
  logic                    we_q;
  logic [`RV_ADR_BITS-1:0] adr_q;
  logic [`RV_XLEN-1:0]     wdat_q;
  logic                    ack_seen;

  assign ack_seen = cyc_q && bus_rsp_i.ack;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cyc_q  <= 1'b0;
      we_q   <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= ack_seen;
      if (start_i) begin
        cyc_q <= 1'b1;
        we_q  <= write_i;
      end else if (ack_seen) begin
        cyc_q <= 1'b0;
      end
    end
  end

  // word accesses only, low address bits ignored
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      adr_q  <= addr_i[`RV_XLEN-1:2];
      wdat_q <= wdata_i;
    end
    if (ack_seen) rdata_o <= bus_rsp_i.dat;
  end

  assign bus_req_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, sel: 4'hf, adr: adr_q, dat: wdat_q};

endmodule

/* verilog/rv_execute.sv */
`include "rv_core_macros.svh"

module rv_execute (
  input  logic                 clk_i,
  input  logic                 load_i,
  input  rv_isa_pkg::decoded_t dec_i,
  input  logic [`RV_XLEN-1:0]  pc_i,
  input  logic [`RV_XLEN-1:0]  rs1_i,
  input  logic [`RV_XLEN-1:0]  rs2_i,
  output logic [`RV_XLEN-1:0]  result_o,
  output logic [`RV_XLEN-1:0]  target_o,
  output logic                 taken_o
);

  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu;
  logic [4:0]          shamt;
  logic                eq, lt, ltu, cond;

  assign op_b  = dec_i.imm_valid ? dec_i.imm : rs2_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec_i.alu_op)
      rv_isa_pkg::ALU_SUB:    alu = rs1_i - op_b;
      rv_isa_pkg::ALU_SLL:    alu = rs1_i << shamt;
      rv_isa_pkg::ALU_SLT:    alu = {31'b0, $signed(rs1_i) < $signed(op_b)};
      rv_isa_pkg::ALU_SLTU:   alu = {31'b0, rs1_i < op_b};
      rv_isa_pkg::ALU_XOR:    alu = rs1_i ^ op_b;
      rv_isa_pkg::ALU_SRL:    alu = rs1_i >> shamt;
      rv_isa_pkg::ALU_SRA:    alu = $signed(rs1_i) >>> shamt;
      rv_isa_pkg::ALU_OR:     alu = rs1_i | op_b;
      rv_isa_pkg::ALU_AND:    alu = rs1_i & op_b;
      rv_isa_pkg::ALU_PASS_B: alu = op_b;
      default:                alu = rs1_i + op_b;
    endcase
  end

  // branches always compare the two registers
  assign eq  = (rs1_i == rs2_i);
  assign lt  = ($signed(rs1_i) < $signed(rs2_i));
  assign ltu = (rs1_i < rs2_i);

  always_comb begin
    case (dec_i.funct3)
      3'b000:  cond = eq;
      3'b001:  cond = !eq;
      3'b100:  cond = lt;
      3'b101:  cond = !lt;
      3'b110:  cond = ltu;
      3'b111:  cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      // link value for jal
      result_o <= dec_i.jal ? pc_i + 32'd4 : alu;
      target_o <= pc_i + dec_i.imm;
      taken_o  <= dec_i.jal || (dec_i.branch && cond);
    end
  end

endmodule

/* verilog/rv_regfile.sv */
`include "rv_core_macros.svh"

module rv_regfile (
  input  logic                    clk_i,
  input  logic                    write_i,
  input  logic [`RV_REG_BITS-1:0] rd_addr_i,
  input  logic [`RV_REG_BITS-1:0] rs1_addr_i,
  input  logic [`RV_REG_BITS-1:0] rs2_addr_i,
  input  logic [`RV_XLEN-1:0]     rd_data_i,
  output logic [`RV_XLEN-1:0]     rs1_o,
  output logic [`RV_XLEN-1:0]     rs2_o
);

  logic [`RV_XLEN-1:0] regs [2**`RV_REG_BITS];

  always_ff @(posedge clk_i) begin
    if (write_i) regs[rd_addr_i] <= rd_data_i;
  end

  // x0 reads as zero regardless of contents
  assign rs1_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  // writeback must already have filtered rd == 0
  a_no_x0_write: assert property (@(posedge clk_i) write_i |-> rd_addr_i != '0);

endmodule

/* verilog/rv_decode.sv */
`include "rv_core_macros.svh"

module rv_decode (
  input  logic                 clk_i,
  input  logic                 load_i,
  input  logic [`RV_XLEN-1:0]  instr_i,
  output rv_isa_pkg::decoded_t dec_o
);

  rv_isa_pkg::decoded_t dec_d;
  logic [`RV_XLEN-1:0]  imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0]           funct3;
  logic                 alt;

  assign funct3 = instr_i[14:12];
  // funct7 bit 5 picks sub and sra
  assign alt    = instr_i[30];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    rv_isa_pkg::alu_op_e arith;
    case (funct3)
      3'b000:  arith = (alt && instr_i[6:0] == rv_isa_pkg::OPC_OP) ? rv_isa_pkg::ALU_SUB
                                                                   : rv_isa_pkg::ALU_ADD;
      3'b001:  arith = rv_isa_pkg::ALU_SLL;
      3'b010:  arith = rv_isa_pkg::ALU_SLT;
      3'b011:  arith = rv_isa_pkg::ALU_SLTU;
      3'b100:  arith = rv_isa_pkg::ALU_XOR;
      3'b101:  arith = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  arith = rv_isa_pkg::ALU_OR;
      default: arith = rv_isa_pkg::ALU_AND;
    endcase

    // anything unrecognized stays a no-op
    dec_d        = '0;
    dec_d.rs1    = instr_i[19:15];
    dec_d.rs2    = instr_i[24:20];
    dec_d.rd     = instr_i[11:7];
    dec_d.funct3 = funct3;
    dec_d.alu_op = rv_isa_pkg::ALU_ADD;
    case (instr_i[6:0])
      rv_isa_pkg::OPC_LUI: begin
        dec_d.imm = imm_u;
        dec_d.imm_valid = 1'b1;
        dec_d.alu_op = rv_isa_pkg::ALU_PASS_B;
        dec_d.reg_write = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        dec_d.imm = imm_j;
        dec_d.jal = 1'b1;
        dec_d.reg_write = 1'b1;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        dec_d.imm = imm_b;
        dec_d.branch = 1'b1;
      end
      rv_isa_pkg::OPC_LOAD: begin
        dec_d.imm = imm_i;
        dec_d.imm_valid = 1'b1;
        dec_d.load = (funct3 == 3'b010);
        dec_d.reg_write = (funct3 == 3'b010);
      end
      rv_isa_pkg::OPC_STORE: begin
        dec_d.imm = imm_s;
        dec_d.imm_valid = 1'b1;
        dec_d.store = (funct3 == 3'b010);
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        dec_d.imm = imm_i;
        dec_d.imm_valid = 1'b1;
        dec_d.alu_op = arith;
        dec_d.reg_write = 1'b1;
      end
      rv_isa_pkg::OPC_OP: begin
        dec_d.alu_op = arith;
        dec_d.reg_write = 1'b1;
      end
      default: dec_d.reg_write = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (load_i) dec_o <= dec_d;
  end

  a_ld_st_excl: assert property (@(posedge clk_i) load_i |=> !(dec_o.load && dec_o.store));

endmodule

/* verilog/rv_prefetch.sv */
`include "rv_core_macros.svh"

module rv_prefetch (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic [`RV_XLEN-1:0]  pc_i,
  input  rv_bus_pkg::bus_rsp_t bus_rsp_i,
  output rv_bus_pkg::bus_req_t bus_req_o,
  output logic [`RV_XLEN-1:0]  instr_o,
  output logic                 done_o
);

  logic                    cyc_q;
  logic [`RV_ADR_BITS-1:0] adr_q;
  logic                    ack_seen;

  assign ack_seen = cyc_q && bus_rsp_i.ack;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cyc_q  <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= ack_seen;
      if (start_i) begin
        cyc_q <= 1'b1;
      end else if (ack_seen) begin
        cyc_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) adr_q <= pc_i[`RV_XLEN-1:2];
    if (ack_seen) instr_o <= bus_rsp_i.dat;
  end

  assign bus_req_o = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, sel: 4'hf, adr: adr_q, dat: '0};

endmodule

/* verilog/rv_bus_arbiter.sv */
module rv_bus_arbiter (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  rv_bus_pkg::bus_req_t fetch_req_i,
  input  rv_bus_pkg::bus_req_t mem_req_i,
  input  logic                 ext_req_i,
  input  rv_bus_pkg::bus_rsp_t bus_rsp_i,
  output rv_bus_pkg::bus_req_t bus_req_o,
  output rv_bus_pkg::bus_rsp_t fetch_rsp_o,
  output rv_bus_pkg::bus_rsp_t mem_rsp_o,
  output logic                 ext_grant_o
);

  rv_bus_pkg::master_e grant_q;

  // fetch is the resting owner, others return to it when done
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      grant_q <= rv_bus_pkg::MST_FETCH;
    end else begin
      case (grant_q)
        rv_bus_pkg::MST_MEM: begin
          if (!mem_req_i.cyc) grant_q <= rv_bus_pkg::MST_FETCH;
        end
        rv_bus_pkg::MST_EXT: begin
          if (!ext_req_i) grant_q <= rv_bus_pkg::MST_FETCH;
        end
        default: begin
          if (!fetch_req_i.cyc) begin
            if (mem_req_i.cyc) begin
              grant_q <= rv_bus_pkg::MST_MEM;
            end else if (ext_req_i) begin
              grant_q <= rv_bus_pkg::MST_EXT;
            end
          end
        end
      endcase
    end
  end

  // external owner drives the slave directly, so the core bus goes idle
  always_comb begin
    case (grant_q)
      rv_bus_pkg::MST_FETCH: bus_req_o = fetch_req_i;
      rv_bus_pkg::MST_MEM:   bus_req_o = mem_req_i;
      default:               bus_req_o = '0;
    endcase
  end

  assign fetch_rsp_o = '{ack: bus_rsp_i.ack && (grant_q == rv_bus_pkg::MST_FETCH),
                         dat: bus_rsp_i.dat};
  assign mem_rsp_o   = '{ack: bus_rsp_i.ack && (grant_q == rv_bus_pkg::MST_MEM),
                         dat: bus_rsp_i.dat};
  assign ext_grant_o = grant_q[2];

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot(grant_q));

  // an open strobe keeps its owner until acked
  a_fetch_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (grant_q == rv_bus_pkg::MST_FETCH && fetch_req_i.stb && !bus_rsp_i.ack)
      |=> grant_q == rv_bus_pkg::MST_FETCH);
  a_mem_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (grant_q == rv_bus_pkg::MST_MEM && mem_req_i.stb && !bus_rsp_i.ack)
      |=> grant_q == rv_bus_pkg::MST_MEM);

endmodule

/* verilog/rv_bus_pkg.sv */
`include "rv_core_macros.svh"

package rv_bus_pkg;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [3:0]              sel;
    logic [`RV_ADR_BITS-1:0] adr;
    logic [`RV_XLEN-1:0]     dat;
  } bus_req_t;

  typedef struct packed {
    logic                ack;
    logic [`RV_XLEN-1:0] dat;
  } bus_rsp_t;

  // one-hot grant encoding
  typedef enum logic [2:0] {
    MST_MEM   = 3'b001,
    MST_FETCH = 3'b010,
    MST_EXT   = 3'b100
  } master_e;

endpackage

/* verilog/rv_isa_pkg.sv */
`include "rv_core_macros.svh"

package rv_isa_pkg;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic [`RV_REG_BITS-1:0] rs1;
    logic [`RV_REG_BITS-1:0] rs2;
    logic [`RV_REG_BITS-1:0] rd;
    logic [`RV_XLEN-1:0]     imm;
    logic                    imm_valid;
    alu_op_e                 alu_op;
    logic [2:0]              funct3;
    logic                    branch;
    logic                    jal;
    logic                    load;
    logic                    store;
    logic                    reg_write;
  } decoded_t;

endpackage

/* verilog/rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// data word width
`define RV_XLEN 32
// register file address width
`define RV_REG_BITS 5
// bus word address width
`define RV_ADR_BITS 30
// first instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

`endif
